// ==== src.f ====
design/pkt_pkg.sv
design/word_fifo.sv
design/packet_ctrl.sv
design/checksum_unit.sv
design/pkt_checksum_top.sv
testbench/tb_pkt_checksum.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f src.f --top-module tb_pkt_checksum -o sim_pkt_checksum

# The simulator exit status is not trusted, the log decides
./obj_dir/sim_pkt_checksum > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"

// ==== testbench/tb_pkt_checksum.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_checksum;

  import pkt_pkg::*;

  localparam int addr_w = 4;
  localparam int depth  = 1 << addr_w;
  localparam int lvl_w  = addr_w + 1;

  logic                  clk;
  logic                  rst_n;
  logic                  clear;
  logic                  push;
  pkt_word_u             in_word;
  logic                  result_valid;
  logic                  fifo_full;
  pkt_result_t           result;
  logic [addr_w:0]       fifo_level;
  logic [7:0]            drop_count;

  pkt_result_t           exp_q [$];   // Results still owed by the DUT

  pkt_checksum_top #(
    .fifo_addr_width (addr_w)
  ) i_pkt_checksum_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .push         (push),
    .in_word      (in_word),
    .result_valid (result_valid),
    .fifo_full    (fifo_full),
    .result       (result),
    .fifo_level   (fifo_level),
    .drop_count   (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ********************
  // Reference model and checks
  // ********************

  function automatic pkt_result_t checksum_ref(opcode_t op, logic [7:0] tag,
                                               logic [15:0] payload [$]);
    pkt_result_t r;
    logic [15:0] acc;
    acc = '0;
    foreach (payload[i]) begin
      case (op)
        op_xor:  acc = acc ^ payload[i];
        op_max:  acc = (payload[i] > acc) ? payload[i] : acc;
        default: acc = acc + payload[i];   // Reserved code sums too
      endcase
    end
    r.opcode   = op;
    r.tag      = tag;
    r.checksum = acc;
    return r;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_result(pkt_result_t got, pkt_result_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: result op %0d tag %h sum %h, expected op %0d tag %h sum %h",
               $time, got.opcode, got.tag, got.checksum, exp.opcode, exp.tag, exp.checksum);
      abort_run();
    end
  endtask

  task automatic check_count(logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: drop_count %0d, expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(logic [addr_w:0] got, logic [addr_w:0] exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Compare every result pulse with the oldest expected packet
  initial begin
    pkt_result_t exp;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid) begin
        if (exp_q.size() == 0) begin
          $display("A result pulse arrived at %0t with no packet outstanding", $time);
          abort_run();
        end else begin
          exp = exp_q.pop_front();
          check_result(result, exp);
        end
      end
    end
  end

  // ********************
  // Stimulus
  // ********************

  task automatic apply_reset();
    rst_n = 1'b0;
    push  = 1'b0;
    clear = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic send_word(pkt_word_u w);
    @(posedge clk);
    #1;
    push    = 1'b1;
    in_word = w;
  endtask

  task automatic stop_push();
    @(posedge clk);
    #1;
    push = 1'b0;
  endtask

  // Sends the header and the first n_sent payload words
  task automatic send_packet(opcode_t op, logic [7:0] tag, int len, int n_sent);
    logic [15:0] payload [$];
    pkt_word_u   w;
    int          i;
    for (i = 0; i < len; i++) payload.push_back(16'($urandom));
    if (n_sent == len) exp_q.push_back(checksum_ref(op, tag, payload));
    w.hdr.opcode = op;
    w.hdr.tag    = tag;
    w.hdr.length = 6'(len);
    send_word(w);
    for (i = 0; i < n_sent; i++) begin
      w.data = payload[i];
      send_word(w);
    end
  endtask

  task automatic wait_results(int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out after %0d cycles waiting for packet results", limit);
      abort_run();
    end
  endtask

  task automatic wait_fifo_empty(int limit);
    int cycles;
    cycles = 0;
    while (fifo_level != '0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (fifo_level != '0) begin
      $display("Timed out after %0d cycles waiting for the FIFO to drain", limit);
      abort_run();
    end
  endtask

  // Occupancy follows the FIFO rules, clear first, then push and pop
  task automatic overflow_check(int n_push);
    int count;
    int drops;
    int i;
    count = 0;
    drops = 0;
    for (i = 0; i < n_push; i++) begin
      @(posedge clk);
      #1;
      clear        = 1'b1;
      push         = 1'b1;
      in_word.data = 16'($urandom);
      @(negedge clk);
      check_flag(fifo_full, count == depth, "fifo_full");
      check_level(fifo_level, lvl_w'(count), "fifo_level");
      if (count == depth && drops < 255) drops++;
      if (clear) count = 0;
      else count = count + ((count != depth) ? 1 : 0) - ((count != 0) ? 1 : 0);
    end
    @(posedge clk);
    #1;
    push  = 1'b0;
    clear = 1'b0;
    @(negedge clk);
    check_level(fifo_level, '0, "fifo_level after clear");
    check_count(drop_count, 8'(drops));
  endtask

  initial begin
    int i;
    int len;
    void'($urandom(67));
    clear   = 1'b0;
    push    = 1'b0;
    in_word = '0;
    apply_reset();

    // One packet per opcode
    for (i = 0; i < 4; i++) begin
      len = $urandom_range(1, 8);
      send_packet(opcode_t'(i), 8'h10 + 8'(i), len, len);
      stop_push();
      wait_results(200);
    end

    send_packet(op_max, 8'h5a, 0, 0);   // Zero length, checksum 0
    stop_push();
    wait_results(200);

    // Back to back, one word every cycle
    for (i = 0; i < 12; i++) begin
      len = $urandom_range(0, 20);
      send_packet(opcode_t'($urandom_range(0, 3)), 8'($urandom), len, len);
    end
    stop_push();
    wait_results(2000);
    check_count(drop_count, 8'd0);

    // Abort a packet halfway through
    send_packet(op_sum, 8'hc3, 10, 4);
    stop_push();
    wait_fifo_empty(100);
    repeat (3) @(posedge clk);
    #1;
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear = 1'b0;
    send_packet(op_xor, 8'h3c, 6, 6);
    stop_push();
    wait_results(200);

    apply_reset();
    overflow_check(24);
    repeat (10) @(posedge clk);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/pkt_checksum_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_checksum_top #(
  parameter int fifo_addr_width = 4
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        clear,
  input  wire                        push,
  input  pkt_pkg::pkt_word_u         in_word,
  output logic                       result_valid,
  output logic                       fifo_full,
  output pkt_pkg::pkt_result_t       result,
  output logic [fifo_addr_width:0]   fifo_level,
  output logic [7:0]                 drop_count
);

  import pkt_pkg::*;

  // ********************
  // Internal wiring
  // ********************

  pkt_word_u     fifo_word;
  logic          fifo_empty;
  logic          pop;
  logic          op_start;
  logic          word_strobe;
  logic          finish;
  opcode_t       hdr_opcode;
  logic [7:0]    hdr_tag;
  logic [15:0]   data_word;

  word_fifo #(
    .addr_width (fifo_addr_width)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (clear),
    .push       (push),
    .pop        (pop),
    .in_word    (in_word),
    .out_word   (fifo_word),
    .empty      (fifo_empty),
    .full       (fifo_full),
    .level      (fifo_level),
    .drop_count (drop_count)
  );

  packet_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .empty       (fifo_empty),
    .out_word    (fifo_word),
    .pop         (pop),
    .op_start    (op_start),
    .word_strobe (word_strobe),
    .finish      (finish),
    .opcode      (hdr_opcode),
    .tag         (hdr_tag),
    .data_word   (data_word)
  );

  checksum_unit u_checksum (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .op_start     (op_start),
    .word_strobe  (word_strobe),
    .finish       (finish),
    .opcode       (hdr_opcode),
    .tag          (hdr_tag),
    .data_word    (data_word),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== design/checksum_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module checksum_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   clear,
  input  wire                   op_start,
  input  wire                   word_strobe,
  input  wire                   finish,
  input  pkt_pkg::opcode_t      opcode,
  input  wire [7:0]             tag,
  input  wire [15:0]            data_word,
  output logic                  result_valid,
  output pkt_pkg::pkt_result_t  result
);

  import pkt_pkg::*;

  opcode_t                cur_op;
  logic [7:0]             cur_tag;
  logic [word_width-1:0]  acc;

  // Accumulator, the header word starts a fresh packet
  always_ff @(posedge clk) begin
    if (op_start) begin
      cur_op  <= opcode;
      cur_tag <= tag;
      acc     <= '0;
    end else if (word_strobe) begin
      case (cur_op)
        op_xor:  acc <= acc ^ data_word;
        op_max:  acc <= (data_word > acc) ? data_word : acc;
        default: acc <= acc + data_word;   // Sum, also the reserved code
      endcase
    end
  end

  // Capture sees the old packet even when op_start is high too
  always_ff @(posedge clk) begin
    if (finish) begin
      result <= '{opcode: cur_op, tag: cur_tag, checksum: acc};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= finish && !clear;
    end
  end

endmodule

`default_nettype wire

// ==== design/packet_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_ctrl (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   clear,
  input  wire                   empty,
  input  pkt_pkg::pkt_word_u    out_word,
  output logic                  pop,
  output logic                  op_start,
  output logic                  word_strobe,
  output logic                  finish,
  output pkt_pkg::opcode_t      opcode,
  output logic [7:0]            tag,
  output logic [15:0]           data_word
);

  import pkt_pkg::*;

  typedef enum logic {
    expect_header,
    in_payload
  } state_t;

  state_t       state;
  logic [5:0]   remaining;    // Payload words still to come
  logic         pop_d;        // out_word holds a fresh word
  logic         word_valid;
  pkt_header_t  hdr;

  // ********************
  // FIFO side
  // ********************

  assign pop = !empty;        // Drain whenever anything is stored

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_d <= 1'b0;
    end else begin
      pop_d <= pop && !clear;  // A word popped during clear is discarded
    end
  end

  assign word_valid = pop_d && !clear;

  // ********************
  // Word decode
  // ********************

  assign hdr       = out_word.hdr;
  assign opcode    = hdr.opcode;
  assign tag       = hdr.tag;
  assign data_word = out_word.data;

  assign op_start    = word_valid && (state == expect_header);
  assign word_strobe = word_valid && (state == in_payload);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= expect_header;
      remaining <= '0;
      finish    <= 1'b0;
    end else if (clear) begin
      state     <= expect_header;  // Abort, no result for this packet
      remaining <= '0;
      finish    <= 1'b0;
    end else begin
      finish <= 1'b0;
      if (op_start) begin
        if (hdr.length == '0) begin
          finish <= 1'b1;          // Empty packet closes right away
        end else begin
          remaining <= hdr.length;
          state     <= in_payload;
        end
      end else if (word_strobe) begin
        if (remaining == 6'd1) begin
          finish <= 1'b1;
          state  <= expect_header;
        end
        remaining <= remaining - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
  parameter int addr_width = 4
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       clear,
  input  wire                       push,
  input  wire                       pop,
  input  pkt_pkg::pkt_word_u        in_word,
  output pkt_pkg::pkt_word_u        out_word,
  output logic                      empty,
  output logic                      full,
  output logic [addr_width:0]       level,
  output logic [7:0]                drop_count
);

  import pkt_pkg::*;

  localparam int depth = 1 << addr_width;

  // ********************
  // Storage and pointers
  // ********************

  pkt_word_u              mem [0:depth-1];
  logic [addr_width-1:0]  wr_ptr;
  logic [addr_width-1:0]  rd_ptr;
  logic [addr_width:0]    count;
  logic                   wr_en;
  logic                   rd_en;

  assign wr_en = push && !full;   // Full FIFO refuses the word
  assign rd_en = pop && !empty;

  // Status straight from the count
  assign empty = (count == '0);
  assign full  = (count == depth[addr_width:0]);
  assign level = count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (wr_en && !rd_en) begin
      count <= count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (clear) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // ********************
  // Data path
  // ********************

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_word;
    end
  end

  // Registered read, word shows up the cycle after the pop
  always_ff @(posedge clk) begin
    if (rd_en) begin
      out_word <= mem[rd_ptr];
    end
  end

  // Refused pushes, survives clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (push && full && drop_count != 8'hff) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

  // ********************
  // Word and packet layout
  // ********************

  localparam int unsigned word_width = 16;

  typedef enum logic [1:0] {
    op_sum  = 2'd0,
    op_xor  = 2'd1,
    op_max  = 2'd2,
    op_rsvd = 2'd3   // Handled as sum
  } opcode_t;

  // First word of every packet
  typedef struct packed {
    opcode_t     opcode;
    logic [7:0]  tag;
    logic [5:0]  length;  // Payload words, 0 to 63
  } pkt_header_t;

  // Same 16 bits seen as a header or as payload data
  typedef union packed {
    pkt_header_t             hdr;
    logic [word_width-1:0]   data;
  } pkt_word_u;

  typedef struct packed {
    opcode_t                 opcode;
    logic [7:0]              tag;
    logic [word_width-1:0]   checksum;
  } pkt_result_t;

endpackage

`default_nettype wire
